// File: include/srt_params.svh
// SRT divider sizes
`ifndef SRT_PARAMS_SVH
`define SRT_PARAMS_SVH

// operand, quotient and remainder width
`define SRT_WIDTH 32

// partial remainder carries one extra sign bit
`define SRT_EXT_WIDTH (`SRT_WIDTH + 1)

// quotient digit select field at the top of the partial remainder
`define SRT_SEL_WIDTH 2

// leading-zero counts and round counter, must hold SRT_WIDTH itself
`define SRT_CNT_WIDTH 6

`endif

// File: design/srt_pkg.sv
// SRT divider types
`include "srt_params.svh"

package srt_pkg;

    // operand, quotient or remainder
    typedef logic [`SRT_WIDTH-1:0] word_t;

    // word with one sign bit on top
    typedef logic [`SRT_EXT_WIDTH-1:0] ext_word_t;

    // leading-zero count or round count
    typedef logic [`SRT_CNT_WIDTH-1:0] count_t;

    // digit select view of the partial remainder
    typedef struct packed {
        logic [`SRT_SEL_WIDTH-1:0]               digit_sel;
        logic [`SRT_EXT_WIDTH-`SRT_SEL_WIDTH-1:0] low;
    } rem_fields_t;

    // arithmetic view and digit select view share one register
    typedef union packed {
        logic signed [`SRT_EXT_WIDTH-1:0] value;
        rem_fields_t                      fields;
    } partial_rem_u;

endpackage

// File: design/leading_zero_count.sv
// Leading zero counter
`timescale 1ns/100ps
`include "srt_params.svh"

module leading_zero_count (
    input  srt_pkg::word_t  data,
    output srt_pkg::count_t zero_count
);

    logic [15:0] half;
    logic [7:0]  quarter;
    logic [3:0]  nibble;
    logic [1:0]  pair;
    logic [4:0]  pos;
    logic        all_zero;

    assign all_zero = (data == '0);

    // each level halves the window, keeping the upper part unless it is empty
    assign pos[4] = (data[31:16] == '0);
    assign half   = pos[4] ? data[15:0] : data[31:16];

    assign pos[3]  = (half[15:8] == '0);
    assign quarter = pos[3] ? half[7:0] : half[15:8];

    assign pos[2] = (quarter[7:4] == '0);
    assign nibble = pos[2] ? quarter[3:0] : quarter[7:4];

    assign pos[1] = (nibble[3:2] == '0);
    assign pair   = pos[1] ? nibble[1:0] : nibble[3:2];

    // last level is a single bit test
    assign pos[0] = ~pair[1];

    // an empty word has no leading one at all
    assign zero_count = all_zero ? srt_pkg::count_t'(`SRT_WIDTH) : {1'b0, pos};

endmodule

// File: design/srt_control.sv
// SRT divider sequencer
`timescale 1ns/100ps
`include "srt_params.svh"

module srt_control (
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  srt_pkg::count_t divisor_lz,
    input  srt_pkg::count_t round_count,
    output logic            load,
    output logic            normalize,
    output logic            step,
    output logic            last_step,
    output logic            finish,
    output logic            busy,
    output logic            done,
    output logic            div_zero
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_NORM,
        S_ITER,
        S_FINISH
    } state_t;

    state_t          state;
    srt_pkg::count_t step_count;
    logic            divisor_zero;

    // divisor with no set bit at all
    assign divisor_zero = (divisor_lz == srt_pkg::count_t'(`SRT_WIDTH));

    assign busy      = (state != S_IDLE);
    assign load      = start && !busy;
    assign normalize = (state == S_NORM);
    assign step      = (state == S_ITER) && (step_count != round_count);
    assign last_step = (state == S_ITER) && (step_count == round_count);
    assign finish    = (state == S_FINISH);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            step_count <= '0;
            done       <= 1'b0;
            div_zero   <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (load) begin
                        state    <= S_NORM;
                        div_zero <= 1'b0;
                    end
                end
                S_NORM: begin
                    step_count <= '0;
                    if (divisor_zero) begin
                        // nothing to iterate so report and go back
                        state    <= S_IDLE;
                        done     <= 1'b1;
                        div_zero <= 1'b1;
                    end else begin
                        state <= S_ITER;
                    end
                end
                S_ITER: begin
                    if (last_step) begin
                        state <= S_FINISH;
                    end else begin
                        step_count <= step_count + srt_pkg::count_t'(1);
                    end
                end
                S_FINISH: begin
                    state <= S_IDLE;
                    done  <= 1'b1;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // every division passes through idle between two done pulses
    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

    // a new operand set is only taken once the previous division reported done
    a_load_idle: assert property (@(posedge clk) disable iff (reset)
        load |-> done || !$past(busy));

endmodule

// File: design/srt_datapath.sv
// SRT operand capture and digit loop
`timescale 1ns/100ps
`include "srt_params.svh"

module srt_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  srt_pkg::word_t        dividend,
    input  srt_pkg::word_t        divisor,
    input  logic                  is_signed,
    input  logic                  load,
    input  logic                  normalize,
    input  logic                  step,
    input  logic                  last_step,
    output srt_pkg::count_t       divisor_lz,
    output srt_pkg::count_t       round_count,
    output srt_pkg::count_t       norm_shift,
    output srt_pkg::partial_rem_u partial_rem,
    output srt_pkg::ext_word_t    divisor_norm,
    output srt_pkg::word_t        pos_q,
    output srt_pkg::word_t        neg_q,
    output logic                  q_sign,
    output logic                  rem_sign
);

    srt_pkg::word_t             dividend_mag;
    srt_pkg::word_t             divisor_mag;
    srt_pkg::count_t            dividend_lz;
    srt_pkg::count_t            min_lz;
    srt_pkg::word_t             rem_shifted;
    srt_pkg::ext_word_t         divisor_shifted;
    srt_pkg::ext_word_t         divisor_neg;
    srt_pkg::ext_word_t         addend;
    logic                       pos_digit;
    logic                       neg_digit;
    logic signed [`SRT_WIDTH:0] next_rem;

    // magnitudes, -2^31 keeps its bit pattern as an unsigned value
    assign dividend_mag = (is_signed && dividend[`SRT_WIDTH-1]) ? -dividend : dividend;
    assign divisor_mag  = (is_signed && divisor[`SRT_WIDTH-1]) ? -divisor : divisor;

    // counts taken on the captured magnitudes
    leading_zero_count i_dividend_lz (
        .data       (partial_rem.value[`SRT_WIDTH-1:0]),
        .zero_count (dividend_lz)
    );

    leading_zero_count i_divisor_lz (
        .data       (divisor_norm[`SRT_WIDTH-1:0]),
        .zero_count (divisor_lz)
    );

    // smaller count keeps a dividend below the divisor in range
    assign min_lz = (dividend_lz < divisor_lz) ? dividend_lz : divisor_lz;

    assign rem_shifted     = partial_rem.value[`SRT_WIDTH-1:0] << min_lz;
    assign divisor_shifted = {1'b0, divisor_norm[`SRT_WIDTH-1:0] << divisor_lz};

    // radix-2 digit from the two top bits
    always_comb begin
        pos_digit = 1'b0;
        neg_digit = 1'b0;
        addend    = '0;
        case (partial_rem.fields.digit_sel)
            2'b01: begin
                pos_digit = 1'b1;
                addend    = divisor_neg;
            end
            2'b10: begin
                neg_digit = 1'b1;
                addend    = divisor_norm;
            end
            default: begin
                addend = '0;
            end
        endcase
    end

    assign next_rem = partial_rem.value + $signed(addend);

    always_ff @(posedge clk) begin
        if (load) begin
            partial_rem.value <= {1'b0, dividend_mag};
            divisor_norm      <= {1'b0, divisor_mag};
            pos_q             <= '0;
            neg_q             <= '0;
            q_sign            <= is_signed && (dividend[`SRT_WIDTH-1] ^ divisor[`SRT_WIDTH-1]);
            rem_sign          <= is_signed && dividend[`SRT_WIDTH-1];
        end else if (normalize) begin
            partial_rem.value <= {1'b0, rem_shifted};
            divisor_norm      <= divisor_shifted;
            divisor_neg       <= -divisor_shifted;
        end else if (step || last_step) begin
            pos_q <= {pos_q[`SRT_WIDTH-2:0], pos_digit};
            neg_q <= {neg_q[`SRT_WIDTH-2:0], neg_digit};
            // final digit leaves the remainder unshifted
            if (step) begin
                partial_rem.value <= {next_rem[`SRT_WIDTH-1:0], 1'b0};
            end else begin
                partial_rem.value <= next_rem;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            round_count <= '0;
            norm_shift  <= '0;
        end else if (normalize) begin
            round_count <= divisor_lz - min_lz;
            norm_shift  <= divisor_lz;
        end
    end

    // control strobes arrive one per cycle at most
    a_strobe_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({normalize, step, last_step}));

endmodule

// File: design/srt_result.sv
// SRT quotient and remainder correction
`timescale 1ns/100ps
`include "srt_params.svh"

module srt_result (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  finish,
    input  srt_pkg::partial_rem_u partial_rem,
    input  srt_pkg::ext_word_t    divisor_norm,
    input  srt_pkg::word_t        pos_q,
    input  srt_pkg::word_t        neg_q,
    input  srt_pkg::count_t       norm_shift,
    input  logic                  q_sign,
    input  logic                  rem_sign,
    output srt_pkg::word_t        quotient,
    output srt_pkg::word_t        remainder
);

    logic               rem_neg;
    srt_pkg::ext_word_t rem_fixed;
    srt_pkg::word_t     rem_mag;
    srt_pkg::word_t     quot_mag;

    // negative final remainder means the quotient is one ulp high
    assign rem_neg = (partial_rem.value < 0);

    assign rem_fixed = rem_neg ? srt_pkg::ext_word_t'(partial_rem.value) + divisor_norm
                               : srt_pkg::ext_word_t'(partial_rem.value);

    // undo the divisor normalization, sign bit is clear here
    assign rem_mag = rem_fixed[`SRT_WIDTH-1:0] >> norm_shift;

    assign quot_mag = pos_q - neg_q - srt_pkg::word_t'(rem_neg);

    always_ff @(posedge clk) begin
        if (reset) begin
            quotient  <= '0;
            remainder <= '0;
        end else if (finish) begin
            quotient  <= q_sign ? -quot_mag : quot_mag;
            // remainder follows the dividend sign
            remainder <= rem_sign ? -rem_mag : rem_mag;
        end
    end

endmodule

// File: design/srt_divider_top.sv
// SRT divider top level
`timescale 1ns/100ps

module srt_divider_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           is_signed,
    input  srt_pkg::word_t dividend,
    input  srt_pkg::word_t divisor,
    output logic           busy,
    output logic           done,
    output logic           div_zero,
    output srt_pkg::word_t quotient,
    output srt_pkg::word_t remainder
);

    logic                  load;
    logic                  normalize;
    logic                  step;
    logic                  last_step;
    logic                  finish;
    logic                  q_sign;
    logic                  rem_sign;
    srt_pkg::count_t       divisor_lz;
    srt_pkg::count_t       round_count;
    srt_pkg::count_t       norm_shift;
    srt_pkg::partial_rem_u partial_rem;
    srt_pkg::ext_word_t    divisor_norm;
    srt_pkg::word_t        pos_q;
    srt_pkg::word_t        neg_q;

    srt_control i_srt_control (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .divisor_lz  (divisor_lz),
        .round_count (round_count),
        .load        (load),
        .normalize   (normalize),
        .step        (step),
        .last_step   (last_step),
        .finish      (finish),
        .busy        (busy),
        .done        (done),
        .div_zero    (div_zero)
    );

    srt_datapath i_srt_datapath (
        .clk          (clk),
        .reset        (reset),
        .dividend     (dividend),
        .divisor      (divisor),
        .is_signed    (is_signed),
        .load         (load),
        .normalize    (normalize),
        .step         (step),
        .last_step    (last_step),
        .divisor_lz   (divisor_lz),
        .round_count  (round_count),
        .norm_shift   (norm_shift),
        .partial_rem  (partial_rem),
        .divisor_norm (divisor_norm),
        .pos_q        (pos_q),
        .neg_q        (neg_q),
        .q_sign       (q_sign),
        .rem_sign     (rem_sign)
    );

    srt_result i_srt_result (
        .clk          (clk),
        .reset        (reset),
        .finish       (finish),
        .partial_rem  (partial_rem),
        .divisor_norm (divisor_norm),
        .pos_q        (pos_q),
        .neg_q        (neg_q),
        .norm_shift   (norm_shift),
        .q_sign       (q_sign),
        .rem_sign     (rem_sign),
        .quotient     (quotient),
        .remainder    (remainder)
    );

endmodule

// File: sim/srt_divider_tb.sv
// SRT divider testbench
`timescale 1ns/100ps
`include "srt_params.svh"

module srt_divider_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int DONE_TIMEOUT = 100;
    localparam int MAX_LATENCY  = 37;
    localparam int NUM_RANDOM   = 200;
    localparam int SEED         = 66;

    logic           clk;
    logic           reset;
    logic           start;
    logic           is_signed;
    srt_pkg::word_t dividend;
    srt_pkg::word_t divisor;
    logic           busy;
    logic           done;
    logic           div_zero;
    srt_pkg::word_t quotient;
    srt_pkg::word_t remainder;

    logic [63:0]    lcg_state;
    srt_pkg::word_t last_q;
    srt_pkg::word_t last_r;

    srt_divider_top i_srt_divider_top (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .is_signed (is_signed),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .div_zero  (div_zero),
        .quotient  (quotient),
        .remainder (remainder)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 64-bit LCG whose upper bits are the better ones
    function automatic srt_pkg::word_t next_random();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state[47:16];
    endfunction

    // random value cut to a random width of 1 to 32 bits
    function automatic srt_pkg::word_t masked_random();
        int             width;
        srt_pkg::word_t mask;
        width = (next_random() % `SRT_WIDTH) + 1;
        mask  = (width == `SRT_WIDTH) ? '1 : ((srt_pkg::word_t'(1) << width) - 1);
        return next_random() & mask;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input srt_pkg::word_t actual, input srt_pkg::word_t expected,
                              input string msg);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t: %s, got %h, expected %h",
                                $time, msg, actual, expected));
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string msg);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t: %s, got %b, expected %b",
                                $time, msg, actual, expected));
        end
    endtask

    // truncating division where the remainder keeps the dividend sign
    // and -2^31 / -1 wraps once cut back to a word
    task automatic model_division(input logic sgn, input srt_pkg::word_t a,
                                  input srt_pkg::word_t b, output srt_pkg::word_t q,
                                  output srt_pkg::word_t r);
        longint sa;
        longint sb;
        sa = sgn ? longint'($signed(a)) : longint'(a);
        sb = sgn ? longint'($signed(b)) : longint'(b);
        q  = srt_pkg::word_t'(sa / sb);
        r  = srt_pkg::word_t'(sa % sb);
    endtask

    task automatic start_division(input logic sgn, input srt_pkg::word_t a,
                                  input srt_pkg::word_t b);
        @(posedge clk);
        is_signed <= sgn;
        dividend  <= a;
        divisor   <= b;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // cycles counted from the edge that accepts start
    task automatic wait_for_done(output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else if (cycles >= DONE_TIMEOUT) begin
                abort_run($sformatf("timeout: no done within %0d cycles at %0t",
                                    DONE_TIMEOUT, $time));
            end
        end
    endtask

    task automatic run_and_check(input logic sgn, input srt_pkg::word_t a,
                                 input srt_pkg::word_t b, input string tag);
        srt_pkg::word_t exp_q;
        srt_pkg::word_t exp_r;
        int             cycles;
        string          name;
        name = $sformatf("%s %h / %h", tag, a, b);
        model_division(sgn, a, b, exp_q, exp_r);
        start_division(sgn, a, b);
        wait_for_done(cycles);
        if (cycles > MAX_LATENCY) begin
            abort_run($sformatf("%s took %0d cycles, more than %0d",
                                name, cycles, MAX_LATENCY));
        end
        check_flag(busy, 1'b0, {name, " busy at done"});
        check_flag(div_zero, 1'b0, {name, " div_zero"});
        check_word(quotient, exp_q, {name, " quotient"});
        check_word(remainder, exp_r, {name, " remainder"});
        @(negedge clk);
        check_flag(done, 1'b0, {name, " done pulse width"});
        last_q = exp_q;
        last_r = exp_r;
    endtask

    task automatic check_div_zero(input logic sgn, input srt_pkg::word_t a);
        int cycles;
        start_division(sgn, a, '0);
        wait_for_done(cycles);
        if (cycles != 2) begin
            abort_run($sformatf("zero divisor gave done after %0d cycles, not 2", cycles));
        end
        check_flag(div_zero, 1'b1, "div_zero on zero divisor");
        check_word(quotient, last_q, "quotient held on zero divisor");
        check_word(remainder, last_r, "remainder held on zero divisor");
        @(negedge clk);
        check_flag(done, 1'b0, "done pulse width on zero divisor");
        check_flag(div_zero, 1'b1, "div_zero held after done");
    endtask

    initial begin
        srt_pkg::word_t a;
        srt_pkg::word_t b;
        srt_pkg::word_t coin;
        srt_pkg::word_t exp_q;
        srt_pkg::word_t exp_r;
        int             cycles;

        lcg_state = 64'(SEED);
        last_q    = '0;
        last_r    = '0;
        reset     <= 1'b1;
        start     <= 1'b0;
        is_signed <= 1'b0;
        dividend  <= '0;
        divisor   <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(div_zero, 1'b0, "div_zero after reset");
        check_word(quotient, '0, "quotient after reset");
        check_word(remainder, '0, "remainder after reset");

        for (int i = 0; i < NUM_RANDOM; i++) begin
            coin = next_random();
            a    = coin[0] ? next_random() : masked_random();
            b    = masked_random();
            if (b == '0) begin
                b = 1;
            end
            run_and_check(1'b0, a, b, "unsigned");
        end

        for (int i = 0; i < NUM_RANDOM; i++) begin
            coin = next_random();
            a    = coin[0] ? next_random() : masked_random();
            b    = masked_random();
            if (b == '0) begin
                b = 1;
            end
            // mix the signs of both operands
            coin = next_random();
            if (coin[0]) begin
                a = -a;
            end
            coin = next_random();
            if (coin[0]) begin
                b = -b;
            end
            run_and_check(1'b1, a, b, "signed");
        end

        run_and_check(1'b0, 32'd0, 32'd12345, "zero dividend");
        run_and_check(1'b1, 32'd0, -32'd77, "zero dividend");
        run_and_check(1'b0, 32'd5, 32'd9, "small dividend");
        run_and_check(1'b1, -32'd5, 32'd9, "small dividend");
        run_and_check(1'b0, 32'd12345, 32'd1, "divisor one");
        run_and_check(1'b1, -32'd7, 32'd1, "divisor one");
        run_and_check(1'b0, 32'h1234_5678, 32'h1234_5678, "equal operands");
        run_and_check(1'b1, -32'd100, -32'd100, "equal operands");
        run_and_check(1'b1, 32'h8000_0000, 32'hFFFF_FFFF, "wrap case");
        run_and_check(1'b0, 32'hFFFF_FFFF, 32'd1, "max dividend");

        run_and_check(1'b1, -32'd1001, 32'd10, "before zero divisor");
        check_div_zero(1'b0, 32'd42);
        check_div_zero(1'b1, -32'd42);
        run_and_check(1'b0, 32'd999, 32'd4, "after zero divisor");

        // second start during a division must be ignored
        model_division(1'b0, 32'd1000000, 32'd7, exp_q, exp_r);
        start_division(1'b0, 32'd1000000, 32'd7);
        @(negedge clk);
        check_flag(busy, 1'b1, "busy after start");
        @(posedge clk);
        is_signed <= 1'b1;
        dividend  <= 32'd99;
        divisor   <= 32'd3;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_done(cycles);
        check_word(quotient, exp_q, "quotient with start while busy");
        check_word(remainder, exp_r, "remainder with start while busy");
        repeat (8) begin
            @(negedge clk);
            check_flag(busy, 1'b0, "idle after ignored start");
            check_word(quotient, exp_q, "quotient held after done");
            check_word(remainder, exp_r, "remainder held after done");
        end
        last_q = exp_q;
        last_r = exp_r;
        run_and_check(1'b1, 32'd99, 32'd3, "after held result");

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
design/srt_pkg.sv
design/leading_zero_count.sv
design/srt_control.sv
design/srt_datapath.sv
design/srt_result.sv
design/srt_divider_top.sv
sim/srt_divider_tb.sv
